/* include/ntm_settings.svh */
//////////////////////////////
// Sizes are fixed at build time. L and N must be at least 2
// Q8.8 constants in the logistic unit assume 8 fraction bits
//////////////////////////////
`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

// Number format
`define NTM_WORD_W 16  // Q8.8 signed word
`define NTM_FRAC_W 8   // Fraction bits
`define NTM_ACC_W  40  // Q24.16 sums, no overflow at these sizes

// Vector sizes
`define NTM_L 4  // Output rows
`define NTM_N 4  // Length of x, r and h

// One index width for rows and columns
`define NTM_IDX_W ((`NTM_L > `NTM_N) ? $clog2(`NTM_L) : $clog2(`NTM_N))

`endif

/* hdl/ntm_fixed_pkg.sv */
//////////////////////////////
// Q8.8 signed words only. No floating point
//////////////////////////////
`include "ntm_settings.svh"

package ntm_fixed_pkg;

  ////////////////////////////// Word types

  // Signed fixed point word
  typedef logic signed [`NTM_WORD_W-1:0] ntm_word_t;

  // Integer byte above fraction byte
  typedef struct packed {
    logic [`NTM_WORD_W-`NTM_FRAC_W-1:0] int_b;  // Whole part
    logic [`NTM_FRAC_W-1:0]             frac_b; // Fraction part
  } ntm_word_parts_t;

  ////////////////////////////// Dual view

  // Same bits read as a number or as two bytes
  // Logistic unit picks segments from both views
  typedef union packed {
    ntm_word_t       raw;   // Whole signed word
    ntm_word_parts_t parts; // Byte split
  } ntm_word_u;

endpackage

/* hdl/ntm_gate_pkg.sv */
//////////////////////////////
// One read vector only. No run-time sizes
//////////////////////////////
package ntm_gate_pkg;

  ////////////////////////////// Host write target

  typedef enum logic [2:0] {
    OP_W,  // Matrix W, row and column
    OP_K,  // Matrix K
    OP_U,  // Matrix U
    OP_X,  // Input vector x, column only
    OP_R,  // Read vector r
    OP_H,  // Hidden vector h
    OP_B   // Bias b
  } ntm_operand_e;

  ////////////////////////////// Controller

  // Matrix and vector pair being read
  typedef enum logic [1:0] {
    TERM_WX,  // W times x, first
    TERM_KR,  // K times r
    TERM_UH   // U times h, last
  } ntm_term_e;

  typedef enum logic [1:0] {
    GATE_IDLE,   // Waiting for start
    GATE_RUN,    // Issuing operand reads
    GATE_DRAIN   // Waiting for last gate value
  } ntm_gate_state_e;

endpackage

/* hdl/ntm_if.sv */
//////////////////////////////
// Operand reads return one cycle after the request
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

////////////////////////////// Operand read bus

interface ntm_operand_rd_if import ntm_fixed_pkg::*, ntm_gate_pkg::*; ();

  ntm_term_e                term;       // Pair select
  logic [`NTM_IDX_W-1:0]    row;        // Matrix row, also bias index
  logic [`NTM_IDX_W-1:0]    col;        // Matrix column and vector index
  ntm_word_t                mat_data;   // Matrix element, registered
  ntm_word_t                vec_data;   // Vector element, registered
  ntm_word_t                bias_data;  // b(row), registered

  modport ctrl   (output term, row, col, input mat_data, vec_data, bias_data);
  modport buffer (input term, row, col, output mat_data, vec_data, bias_data);

endinterface

////////////////////////////// MAC stream

interface ntm_mac_if import ntm_fixed_pkg::*; ();

  logic      valid;      // One operand pair this cycle
  logic      first;      // Bias preload beat
  logic      last;       // Closing beat of a row
  ntm_word_t a;          // Matrix element
  ntm_word_t b;          // Vector element
  ntm_word_t bias;       // Row bias, used on first
  logic      acc_valid;  // One cycle after last
  ntm_word_t z;          // Saturated row sum

  modport ctrl (output valid, first, last, a, b, bias, input acc_valid, z);
  modport mac  (input valid, first, last, a, b, bias, output acc_valid, z);

endinterface

/* hdl/ntm_operand_buffer.sv */
//////////////////////////////
// Vectors take wr_col as index, b included
// Writes during a run corrupt that run
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_operand_buffer
  import ntm_fixed_pkg::*, ntm_gate_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  wr_en,    // Host write strobe
  input  ntm_operand_e          wr_sel,   // Target array
  input  logic [`NTM_IDX_W-1:0] wr_row,   // Matrices only
  input  logic [`NTM_IDX_W-1:0] wr_col,
  input  ntm_word_t             wr_data,
  ntm_operand_rd_if.buffer      rd
);

  ntm_word_t w_mem [`NTM_L][`NTM_N];
  ntm_word_t k_mem [`NTM_L][`NTM_N];
  ntm_word_t u_mem [`NTM_L][`NTM_N];
  ntm_word_t x_vec [`NTM_N];
  ntm_word_t r_vec [`NTM_N];
  ntm_word_t h_vec [`NTM_N];
  ntm_word_t b_vec [`NTM_L];

  ////////////////////////////// Write port

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < `NTM_L; l++) begin
        for (int n = 0; n < `NTM_N; n++) begin
          w_mem[l][n] <= '0;
          k_mem[l][n] <= '0;
          u_mem[l][n] <= '0;
        end
        b_vec[l] <= '0;
      end
      for (int n = 0; n < `NTM_N; n++) begin
        x_vec[n] <= '0;
        r_vec[n] <= '0;
        h_vec[n] <= '0;
      end
    end else if (wr_en) begin
      case (wr_sel)
        OP_W:    w_mem[wr_row][wr_col] <= wr_data;
        OP_K:    k_mem[wr_row][wr_col] <= wr_data;
        OP_U:    u_mem[wr_row][wr_col] <= wr_data;
        OP_X:    x_vec[wr_col] <= wr_data;
        OP_R:    r_vec[wr_col] <= wr_data;
        OP_H:    h_vec[wr_col] <= wr_data;
        OP_B:    b_vec[wr_col] <= wr_data;  // Bias indexed by column too
        default: ;                          // Unused codes dropped
      endcase
    end
  end

  ////////////////////////////// Registered read

  // Pair picked by term, bias by row
  always_ff @(posedge CLK) begin
    case (rd.term)
      TERM_WX: begin
        rd.mat_data <= w_mem[rd.row][rd.col];
        rd.vec_data <= x_vec[rd.col];
      end
      TERM_KR: begin
        rd.mat_data <= k_mem[rd.row][rd.col];
        rd.vec_data <= r_vec[rd.col];
      end
      default: begin
        rd.mat_data <= u_mem[rd.row][rd.col];
        rd.vec_data <= h_vec[rd.col];
      end
    endcase
    rd.bias_data <= b_vec[rd.row];
  end

endmodule

/* hdl/ntm_matrix_vector_mac.sv */
//////////////////////////////
// first and last must not share a beat
// Result rounds toward minus infinity, then saturates
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_matrix_vector_mac (
  input  logic    CLK,
  input  logic    RST,
  ntm_mac_if.mac  mac
);

  localparam int W  = `NTM_WORD_W;
  localparam int AW = `NTM_ACC_W;

  // Q8.8 limits seen at accumulator scale
  localparam logic signed [AW-1:0] Z_MAX = AW'((1 << (W - 1)) - 1);
  localparam logic signed [AW-1:0] Z_MIN = -AW'(1 << (W - 1));

  logic signed [2*W-1:0] prod;      // Q16.16 product
  logic signed [AW-1:0]  prod_ext;
  logic signed [AW-1:0]  bias_ext;  // Bias at product scale
  logic signed [AW-1:0]  acc;
  logic signed [AW-1:0]  acc_sh;    // Back to Q8.8 scale

  assign prod     = mac.a * mac.b;
  assign prod_ext = {{(AW - 2 * W){prod[2*W-1]}}, prod};
  assign bias_ext = {{(AW - W){mac.bias[W-1]}}, mac.bias} <<< `NTM_FRAC_W;

  ////////////////////////////// Accumulator

  always_ff @(posedge CLK) begin
    if (mac.valid) begin
      if (mac.first) acc <= bias_ext + prod_ext;  // New row
      else           acc <= acc + prod_ext;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) mac.acc_valid <= 1'b0;
    else     mac.acc_valid <= mac.valid & mac.last;  // Row sum ready next cycle
  end

  ////////////////////////////// Scale and clip

  assign acc_sh = acc >>> `NTM_FRAC_W;  // Floor shift

  always_comb begin
    if (acc_sh > Z_MAX)      mac.z = Z_MAX[W-1:0];  // Large positive weights
    else if (acc_sh < Z_MIN) mac.z = Z_MIN[W-1:0];
    else                     mac.z = acc_sh[W-1:0];
  end

endmodule

/* hdl/ntm_vector_logistic.sv */
//////////////////////////////
// Piecewise-linear sigmoid, 4 segments
// Output ready 2 cycles after input
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_vector_logistic
  import ntm_fixed_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  in_valid,
  input  logic [`NTM_IDX_W-1:0] in_index,   // Row tag
  input  ntm_word_t             z,
  output logic                  out_valid,
  output logic [`NTM_IDX_W-1:0] out_index,
  output ntm_word_t             o           // Q8.8 in 0..1
);

  localparam int F = `NTM_FRAC_W;

  // Segment offsets and limits in Q8.8
  localparam ntm_word_t ONE    = ntm_word_t'(1 << F);          // 1.0
  localparam ntm_word_t OFS_0  = ntm_word_t'(1 << (F - 1));    // 0.5
  localparam ntm_word_t OFS_1  = ntm_word_t'(5 << (F - 3));    // 0.625
  localparam ntm_word_t OFS_2  = ntm_word_t'(27 << (F - 5));   // 0.84375
  localparam ntm_word_t KNEE_2 = ntm_word_t'(19 << (F - 3));   // 2.375

  logic [`NTM_WORD_W-1:0] mag;     // 0x8000 stays large as unsigned
  ntm_word_u              mag_u;
  logic [1:0]             seg;

  logic                   s1_valid;
  logic [`NTM_IDX_W-1:0]  s1_index;
  logic                   s1_neg;
  logic [1:0]             s1_seg;
  logic [`NTM_WORD_W-1:0] s1_mag;
  ntm_word_t              pos;     // Result for |z|

  ////////////////////////////// Stage 1

  assign mag       = z[`NTM_WORD_W-1] ? (~z + 1'b1) : z;
  assign mag_u.raw = mag;

  always_comb begin
    if (mag_u.parts.int_b >= 5)     seg = 2'd3;  // Flat at 1.0
    else if (mag_u.parts.int_b == 0) seg = 2'd0;  // Below 1.0
    else if (mag_u.raw < KNEE_2)    seg = 2'd1;
    else                            seg = 2'd2;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) s1_valid <= 1'b0;
    else     s1_valid <= in_valid;
  end

  always_ff @(posedge CLK) begin
    s1_index <= in_index;
    s1_neg   <= z[`NTM_WORD_W-1];
    s1_seg   <= seg;
    s1_mag   <= mag;
  end

  ////////////////////////////// Stage 2

  // Slope by shift plus offset
  always_comb begin
    case (s1_seg)
      2'd0:    pos = ntm_word_t'(s1_mag >> 2) + OFS_0;
      2'd1:    pos = ntm_word_t'(s1_mag >> 3) + OFS_1;
      2'd2:    pos = ntm_word_t'(s1_mag >> 5) + OFS_2;
      default: pos = ONE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) out_valid <= 1'b0;
    else     out_valid <= s1_valid;
  end

  always_ff @(posedge CLK) begin
    out_index <= s1_index;
    o         <= s1_neg ? (ONE - pos) : pos;  // sigmoid(-m) = 1 - sigmoid(m)
  end

endmodule

/* hdl/ntm_output_gate_vector.sv */
//////////////////////////////
// Rows go out in order, one value each, then done
// start is ignored while busy
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_output_gate_vector
  import ntm_fixed_pkg::*, ntm_gate_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  output logic                  busy,
  ntm_operand_rd_if.ctrl        rd,
  output logic                  o_valid,
  output logic [`NTM_IDX_W-1:0] o_index,
  output ntm_word_t             o_data,
  output logic                  done
);

  localparam int IW = `NTM_IDX_W;
  localparam logic [IW-1:0] LAST_ROW = IW'(`NTM_L - 1);
  localparam logic [IW-1:0] LAST_COL = IW'(`NTM_N - 1);

  ntm_gate_state_e state;
  ntm_term_e       term;
  logic [IW-1:0]   row;
  logic [IW-1:0]   col;
  logic [IW-1:0]   res_row;    // Row of the next MAC result
  logic [IW-1:0]   out_cnt;    // Gate values seen this run

  logic issue;
  logic issue_first;
  logic issue_last;
  logic end_of_run;
  logic mac_valid;             // Read strobes, one cycle late
  logic mac_first;
  logic mac_last;

  ntm_mac_if mac_bus ();

  function automatic ntm_term_e next_term(input ntm_term_e t);
    case (t)
      TERM_WX: return TERM_KR;
      TERM_KR: return TERM_UH;
      default: return TERM_WX;
    endcase
  endfunction

  ////////////////////////////// Read issue

  assign issue       = (state == GATE_RUN);  // One read per cycle
  assign issue_first = issue && (term == TERM_WX) && (col == '0);
  assign issue_last  = issue && (term == TERM_UH) && (col == LAST_COL);
  assign end_of_run  = issue_last && (row == LAST_ROW);
  assign busy        = (state != GATE_IDLE);

  assign rd.term = term;
  assign rd.row  = row;
  assign rd.col  = col;

  ////////////////////////////// FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= GATE_IDLE;
      term  <= TERM_WX;
      row   <= '0;
      col   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        GATE_IDLE: begin
          if (start) begin
            state <= GATE_RUN;
            term  <= TERM_WX;
            row   <= '0;
            col   <= '0;
          end
        end
        GATE_RUN: begin
          if (col == LAST_COL) begin
            col  <= '0;
            term <= next_term(term);
            if (term == TERM_UH) row <= row + 1'b1;  // Row complete
            if (end_of_run) state <= GATE_DRAIN;
          end else begin
            col <= col + 1'b1;
          end
        end
        GATE_DRAIN: begin
          // Busy drops with done
          if (o_valid && (out_cnt == LAST_ROW)) begin
            state <= GATE_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= GATE_IDLE;
      endcase
    end
  end

  // Align strobes with read data
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mac_valid <= 1'b0;
      mac_first <= 1'b0;
      mac_last  <= 1'b0;
    end else begin
      mac_valid <= issue;
      mac_first <= issue_first;
      mac_last  <= issue_last;
    end
  end

  // Result tags and output count
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res_row <= '0;
      out_cnt <= '0;
    end else if (!busy && start) begin
      res_row <= '0;
      out_cnt <= '0;
    end else begin
      if (mac_bus.acc_valid) res_row <= res_row + 1'b1;
      if (o_valid)           out_cnt <= out_cnt + 1'b1;
    end
  end

  ////////////////////////////// Datapath

  assign mac_bus.valid = mac_valid;
  assign mac_bus.first = mac_first;
  assign mac_bus.last  = mac_last;
  assign mac_bus.a     = rd.mat_data;
  assign mac_bus.b     = rd.vec_data;
  assign mac_bus.bias  = rd.bias_data;

  ntm_matrix_vector_mac u_mac (
    .CLK (CLK),
    .RST (RST),
    .mac (mac_bus.mac)
  );

  // Overlaps the MAC of the next row
  ntm_vector_logistic u_logistic (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (mac_bus.acc_valid),
    .in_index  (res_row),
    .z         (mac_bus.z),
    .out_valid (o_valid),
    .out_index (o_index),
    .o         (o_data)
  );

endmodule

/* hdl/ntm_output_gate_top.sv */
//////////////////////////////
// No back-pressure. Take o_data on o_valid
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_output_gate_top
  import ntm_fixed_pkg::*, ntm_gate_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Host load
  input  logic                  wr_en,
  input  ntm_operand_e          wr_sel,
  input  logic [`NTM_IDX_W-1:0] wr_row,
  input  logic [`NTM_IDX_W-1:0] wr_col,
  input  ntm_word_t             wr_data,
  // Run control
  input  logic                  start,
  output logic                  busy,
  // Gate values
  output logic                  o_valid,
  output logic [`NTM_IDX_W-1:0] o_index,
  output ntm_word_t             o_data,
  output logic                  done
);

  ntm_operand_rd_if rd_bus ();

  ntm_operand_buffer u_buffer (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_row  (wr_row),
    .wr_col  (wr_col),
    .wr_data (wr_data),
    .rd      (rd_bus.buffer)
  );

  ntm_output_gate_vector u_gate (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .busy    (busy),
    .rd      (rd_bus.ctrl),
    .o_valid (o_valid),
    .o_index (o_index),
    .o_data  (o_data),
    .done    (done)
  );

endmodule

/* verif/ntm_output_gate_tasks.svh */
//////////////////////////////
// Included inside the testbench module
// Uses its signals, model arrays and counters
//////////////////////////////
`ifndef NTM_OUTPUT_GATE_TASKS_SVH
`define NTM_OUTPUT_GATE_TASKS_SVH

////////////////////////////// Drivers

function automatic void clear_model();
  for (int l = 0; l < L; l++) begin
    for (int n = 0; n < N; n++) begin
      w_ref[l][n] = 0;
      k_ref[l][n] = 0;
      u_ref[l][n] = 0;
    end
    b_ref[l] = 0;
  end
  for (int n = 0; n < N; n++) begin
    x_ref[n] = 0;
    r_ref[n] = 0;
    h_ref[n] = 0;
  end
endfunction

// Values within +-span LSBs
function automatic void randomize_model(input int span);
  for (int l = 0; l < L; l++) begin
    for (int n = 0; n < N; n++) begin
      w_ref[l][n] = $random(seed) % span;
      k_ref[l][n] = $random(seed) % span;
      u_ref[l][n] = $random(seed) % span;
    end
    b_ref[l] = $random(seed) % span;
  end
  for (int n = 0; n < N; n++) begin
    x_ref[n] = $random(seed) % span;
    r_ref[n] = $random(seed) % span;
    h_ref[n] = $random(seed) % span;
  end
endfunction

task automatic write_operand(input ntm_operand_e sel, input int row, input int col,
                             input int value);
  @(negedge CLK);
  wr_en   = 1'b1;  // Held high across back-to-back writes
  wr_sel  = sel;
  wr_row  = IW'(row);
  wr_col  = IW'(col);
  wr_data = ntm_word_t'(value);
endtask

// Whole model into the buffer
task automatic push_model();
  for (int l = 0; l < L; l++) begin
    for (int n = 0; n < N; n++) begin
      write_operand(OP_W, l, n, w_ref[l][n]);
      write_operand(OP_K, l, n, k_ref[l][n]);
      write_operand(OP_U, l, n, u_ref[l][n]);
    end
    write_operand(OP_B, 0, l, b_ref[l]);  // Bias takes the column index
  end
  for (int n = 0; n < N; n++) begin
    write_operand(OP_X, 0, n, x_ref[n]);
    write_operand(OP_R, 0, n, r_ref[n]);
    write_operand(OP_H, 0, n, h_ref[n]);
  end
  @(negedge CLK);
  wr_en = 1'b0;
endtask

task automatic pulse_start();
  @(negedge CLK);
  start = 1'b1;
  @(negedge CLK);
  start = 1'b0;
endtask

////////////////////////////// Checkers

task automatic mark_run();
  run_out_base  = got_value.size();
  run_done_base = done_cnt;
endtask

task automatic wait_for_done(input string label);
  int cycles;
  cycles = 0;
  while (done_cnt == run_done_base && cycles < RUN_TIMEOUT) begin
    @(negedge CLK);
    cycles++;
  end
  if (done_cnt == run_done_base) begin
    $display("%s: no done strobe within %0d cycles", label, RUN_TIMEOUT);
    flow_errors++;
  end
endtask

// First gate value of the current run
task automatic wait_for_first_output(input string label);
  int cycles;
  cycles = 0;
  while (got_value.size() == run_out_base && cycles < RUN_TIMEOUT) begin
    @(negedge CLK);
    cycles++;
  end
  if (got_value.size() == run_out_base) begin
    $display("%s: no gate value within %0d cycles", label, RUN_TIMEOUT);
    flow_errors++;
  end
endtask

task automatic check_outputs(input string label);
  int n_out;
  int want;
  n_out = got_value.size() - run_out_base;
  if (n_out != L) begin
    $display("%s: %0d gate values seen where %0d were expected", label, n_out, L);
    flow_errors++;
  end
  if (done_cnt - run_done_base != 1) begin
    $display("%s: %0d done strobes seen where one was expected", label,
             done_cnt - run_done_base);
    flow_errors++;
  end
  if (busy) begin
    $display("%s: busy still high after done", label);
    flow_errors++;
  end
  for (int l = 0; l < L && l < n_out; l++) begin
    want = sigmoid_pwl(row_sum(l));
    if (got_index[run_out_base + l] != l) begin
      $display("FAILED at %0t: %s output %0d has index %0d", $time, label, l,
               got_index[run_out_base + l]);
      value_errors++;
    end
    if (got_value[run_out_base + l] != want) begin
      $display("FAILED at %0t: %s row %0d gave 0x%04h, expected 0x%04h", $time, label,
               l, got_value[run_out_base + l] & 16'hffff, want & 16'hffff);
      value_errors++;
    end
  end
endtask

task automatic run_and_check(input string label);
  mark_run();
  pulse_start();
  wait_for_done(label);
  repeat (4) @(negedge CLK);  // Room for a stray strobe
  check_outputs(label);
endtask

////////////////////////////// Directed tests

task automatic reset_stays_quiet();
  int seen;
  seen = 0;
  for (int c = 0; c < 16; c++) begin
    @(negedge CLK);
    if (busy || o_valid || done) seen++;
  end
  if (seen != 0) begin
    $display("FAILED at %0t: busy, o_valid or done high on %0d idle cycles", $time, seen);
    value_errors++;
  end
endtask

// Each segment with both signs, plus beyond +-5
task automatic bias_only_rows();
  int bias_tab [8] = '{64, -384, 768, -1536, -192, 512, -608, 1792};
  for (int p = 0; p < 2; p++) begin
    clear_model();
    randomize_model(256);
    for (int l = 0; l < L; l++) begin
      for (int n = 0; n < N; n++) begin
        w_ref[l][n] = 0;
        k_ref[l][n] = 0;
        u_ref[l][n] = 0;
      end
      b_ref[l] = bias_tab[(p * L + l) % 8];
    end
    push_model();
    run_and_check("bias only");
  end
endtask

// Identity in one matrix proves the pair routing
task automatic one_term_at_a_time();
  string names [3] = '{"term WX", "term KR", "term UH"};
  for (int t = 0; t < 3; t++) begin
    clear_model();
    for (int n = 0; n < N; n++) begin
      x_ref[n] = $random(seed) % 256;
      r_ref[n] = $random(seed) % 256;
      h_ref[n] = $random(seed) % 256;
    end
    for (int l = 0; l < L; l++) begin
      b_ref[l] = $random(seed) % 256;
      if (l < N) begin
        case (t)
          0:       w_ref[l][l] = 256;  // 1.0
          1:       k_ref[l][l] = 256;
          default: u_ref[l][l] = 256;
        endcase
      end
    end
    push_model();
    run_and_check(names[t]);
  end
endtask

task automatic random_operand_run();
  randomize_model(384);
  push_model();
  run_and_check("random");
endtask

// Even rows clip high, odd rows clip low
task automatic saturating_products();
  clear_model();
  for (int n = 0; n < N; n++) x_ref[n] = 32512;  // 127.0
  for (int l = 0; l < L; l++) begin
    for (int n = 0; n < N; n++) w_ref[l][n] = (l % 2 == 0) ? 32512 : -32512;
  end
  push_model();
  run_and_check("saturation");
endtask

task automatic start_while_busy();
  randomize_model(384);
  push_model();
  mark_run();
  pulse_start();
  wait_for_first_output("control");  // A restart now would add rows
  if (!busy) begin
    $display("control: controller not busy when the second start was sent");
    flow_errors++;
  end
  pulse_start();
  wait_for_done("control");
  repeat (30) @(negedge CLK);  // A second run would show here
  check_outputs("ignored start");
  randomize_model(384);
  push_model();
  run_and_check("back to back 1");
  randomize_model(384);
  push_model();
  run_and_check("back to back 2");
endtask

`endif

/* verif/ntm_output_gate_tb.sv */
//////////////////////////////
// Directed tests of the output gate top level
// Reference model uses Q8.8 with 8 fraction bits
//////////////////////////////
`timescale 1ns/1ns
`include "ntm_settings.svh"

module ntm_output_gate_tb
  import ntm_fixed_pkg::*, ntm_gate_pkg::*;
();

  localparam int L           = `NTM_L;
  localparam int N           = `NTM_N;
  localparam int IW          = `NTM_IDX_W;
  localparam int RUN_TIMEOUT = 400;  // Cycles allowed for one run

  logic            CLK;
  logic            RST;
  logic            wr_en;
  ntm_operand_e    wr_sel;
  logic [IW-1:0]   wr_row;
  logic [IW-1:0]   wr_col;
  ntm_word_t       wr_data;
  logic            start;
  logic            busy;
  logic            o_valid;
  logic [IW-1:0]   o_index;
  ntm_word_t       o_data;
  logic            done;

  // Reference copy of the operand storage
  int w_ref [L][N];
  int k_ref [L][N];
  int u_ref [L][N];
  int x_ref [N];
  int r_ref [N];
  int h_ref [N];
  int b_ref [L];

  int     got_index [$];   // Filled by the collector only
  int     got_value [$];
  int     done_cnt;
  int     run_out_base;    // Queue position at start of a run
  int     run_done_base;
  int     value_errors;
  int     flow_errors;
  integer seed;

  ////////////////////////////// Clock and DUT

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;  // 10 ns period

  ntm_output_gate_top dut0 (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_row  (wr_row),
    .wr_col  (wr_col),
    .wr_data (wr_data),
    .start   (start),
    .busy    (busy),
    .o_valid (o_valid),
    .o_index (o_index),
    .o_data  (o_data),
    .done    (done)
  );

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (o_valid) begin
      got_index.push_back(int'(o_index));
      got_value.push_back(int'(o_data));
    end
    if (done) done_cnt++;
  end

  ////////////////////////////// Reference model

  // Bias preload, three products per column, floor shift, clip to 16 bits
  function automatic int row_sum(input int l);
    longint acc;
    longint z;
    acc = longint'(b_ref[l]) * 256;
    for (int n = 0; n < N; n++) begin
      acc += longint'(w_ref[l][n]) * x_ref[n];
      acc += longint'(k_ref[l][n]) * r_ref[n];
      acc += longint'(u_ref[l][n]) * h_ref[n];
    end
    z = acc >>> 8;
    if (z > 32767) z = 32767;
    else if (z < -32768) z = -32768;
    return int'(z);
  endfunction

  // Breakpoints 1.0, 2.375 and 5.0 in Q8.8
  function automatic int sigmoid_pwl(input int z);
    int m;
    int p;
    m = (z < 0) ? -z : z;
    if (m >= 1280)     p = 256;
    else if (m < 256)  p = (m >> 2) + 128;
    else if (m < 608)  p = (m >> 3) + 160;
    else               p = (m >> 5) + 216;
    return (z < 0) ? (256 - p) : p;  // Mirror for negative sums
  endfunction

  `include "ntm_output_gate_tasks.svh"

  ////////////////////////////// Sequence

  initial begin
    seed          = 32'hf3e3;
    RST           = 1'b1;
    wr_en         = 1'b0;
    wr_sel        = OP_W;
    wr_row        = '0;
    wr_col        = '0;
    wr_data       = '0;
    start         = 1'b0;
    done_cnt      = 0;
    run_out_base  = 0;
    run_done_base = 0;
    value_errors  = 0;
    flow_errors   = 0;
    clear_model();
    repeat (8) @(negedge CLK);
    RST = 1'b0;
    reset_stays_quiet();
    bias_only_rows();
    one_term_at_a_time();
    random_operand_run();
    saturating_products();
    start_while_busy();
    $display("Errors: %0d wrong values, %0d handshake or timeout", value_errors, flow_errors);
    if (value_errors + flow_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
+incdir+verif
hdl/ntm_fixed_pkg.sv
hdl/ntm_gate_pkg.sv
hdl/ntm_if.sv
hdl/ntm_operand_buffer.sv
hdl/ntm_matrix_vector_mac.sv
hdl/ntm_vector_logistic.sv
hdl/ntm_output_gate_vector.sv
hdl/ntm_output_gate_top.sv
verif/ntm_output_gate_tb.sv

/* Makefile */
# Verilator flow for the output gate testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= ntm_output_gate_tb
DUT_TOP   ?= ntm_output_gate_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
